/* design/dma_defines.svh */
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// Byte address and data word widths
`define DMA_ADDR_WIDTH 32
`define DMA_DATA_WIDTH 32

// Transfer length in bytes
`define DMA_LEN_WIDTH 16

// Id width shared by the OBI and init ports
`define DMA_ID_WIDTH 2

// Granted OBI reads that may still wait for their data
`define DMA_MAX_OUTSTANDING 4

// Entries in each FIFO between stages
`define DMA_FIFO_DEPTH 4

`endif

/* design/dma_pkg.sv */
`include "dma_defines.svh"

package dma_pkg;

    typedef logic [`DMA_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [`DMA_DATA_WIDTH-1:0]   data_t;
    typedef logic [`DMA_DATA_WIDTH/8-1:0] strb_t;
    typedef logic [`DMA_LEN_WIDTH-1:0]    len_t;
    typedef logic [`DMA_ID_WIDTH-1:0]     id_t;

    // Fill levels of a stage FIFO and of the outstanding-read tracker
    typedef logic [$clog2(`DMA_FIFO_DEPTH+1)-1:0]      fifo_cnt_t;
    typedef logic [$clog2(`DMA_MAX_OUTSTANDING+1)-1:0] out_cnt_t;

    typedef enum logic [1:0] {
        ERR_NONE   = 2'd0,
        ERR_DECODE = 2'd1,
        ERR_READ   = 2'd2
    } err_kind_e;

    // One word to move, as produced by the decoder
    typedef struct packed {
        addr_t src_addr;
        addr_t dst_addr;
        logic  first;
        logic  last;
        logic  tf_last;
        logic  reject;   // Refused at decode, skips both read and write
    } read_beat_t;

    // A word after its read, with the returned data and status
    typedef struct packed {
        addr_t dst_addr;
        logic  first;
        logic  last;
        logic  tf_last;
        logic  reject;
        data_t data;
        logic  rd_err;
        addr_t src_addr;
    } data_beat_t;

endpackage

/* design/dma_stream_fifo.sv */
module dma_stream_fifo #(
    parameter type         payload_t = logic,
    parameter int unsigned DEPTH     = 4
) (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       in_valid_i,
    output logic                       in_ready_o,
    input  payload_t                   in_data_i,
    output logic                       out_valid_o,
    input  logic                       out_ready_i,
    output payload_t                   out_data_o,
    output logic [$clog2(DEPTH+1)-1:0] count_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t                   mem_q [DEPTH];
    logic [PTR_W-1:0]           wr_ptr_q;
    logic [PTR_W-1:0]           rd_ptr_q;
    logic [$clog2(DEPTH+1)-1:0] count_q;
    logic                       push;
    logic                       pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready_o  = count_q != DEPTH;
    assign out_valid_o = count_q != '0;
    assign out_data_o  = mem_q[rd_ptr_q];
    assign count_o     = count_q;
    assign push        = in_valid_i && in_ready_o;
    assign pop         = out_valid_o && out_ready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_data_i;
        end
    end

    // A producer held off by a full buffer keeps offering the same payload
    assert property (@(posedge clk_i) disable iff (reset_i)
        in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_data_i));

endmodule

/* design/dma_burst_decoder.sv */
module dma_burst_decoder import dma_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       req_valid_i,
    output logic       req_ready_o,
    input  len_t       req_length_i,
    input  addr_t      req_src_addr_i,
    input  addr_t      req_dst_addr_i,
    input  logic       req_last_i,
    output logic       beat_valid_o,
    input  logic       beat_ready_i,
    output read_beat_t beat_o,
    output logic       busy_o
);

    localparam int unsigned WORD_BYTES  = $bits(strb_t);
    localparam int unsigned OFFSET_BITS = $clog2(WORD_BYTES);

    logic  ready_q;
    logic  active_q;
    addr_t src_q;
    addr_t dst_q;
    len_t  words_q;
    logic  first_q;
    logic  tf_last_q;
    logic  reject_q;
    logic  req_fire;
    logic  beat_fire;
    len_t  req_words;

    assign req_fire  = req_valid_i && ready_q;
    assign beat_fire = beat_valid_o && beat_ready_i;
    // Low length bits are ignored, transfers are whole words
    assign req_words = req_length_i >> OFFSET_BITS;

    assign req_ready_o  = ready_q;
    assign beat_valid_o = active_q;
    assign busy_o       = active_q;

    always_comb begin
        beat_o.src_addr = src_q;
        beat_o.dst_addr = dst_q;
        beat_o.first    = first_q;
        beat_o.last     = reject_q || (words_q == len_t'(1));
        beat_o.tf_last  = tf_last_q;
        beat_o.reject   = reject_q;
    end

    // Ready comes back one cycle after the final beat leaves
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ready_q  <= 1'b0;
            active_q <= 1'b0;
        end else if (req_fire) begin
            ready_q  <= 1'b0;
            active_q <= 1'b1;
        end else if (beat_fire && beat_o.last) begin
            ready_q  <= 1'b1;
            active_q <= 1'b0;
        end else if (!active_q) begin
            ready_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            src_q     <= req_src_addr_i & ~addr_t'(WORD_BYTES - 1);
            dst_q     <= req_dst_addr_i & ~addr_t'(WORD_BYTES - 1);
            words_q   <= req_words;
            first_q   <= 1'b1;
            tf_last_q <= req_last_i;
            reject_q  <= req_words == '0;
        end else if (beat_fire) begin
            src_q   <= src_q + addr_t'(WORD_BYTES);
            dst_q   <= dst_q + addr_t'(WORD_BYTES);
            words_q <= words_q - 1'b1;
            first_q <= 1'b0;
        end
    end

    assert property (@(posedge clk_i) disable iff (reset_i)
        beat_valid_o && !beat_ready_i |=> beat_valid_o && $stable(beat_o));

endmodule

/* design/dma_obi_reader.sv */
`include "dma_defines.svh"

module dma_obi_reader import dma_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       beat_valid_i,
    output logic       beat_ready_o,
    input  read_beat_t beat_i,
    output logic       obi_req_o,
    output addr_t      obi_addr_o,
    output logic       obi_we_o,
    output strb_t      obi_be_o,
    output id_t        obi_id_o,
    input  logic       obi_gnt_i,
    input  logic       obi_rvalid_i,
    input  data_t      obi_rdata_i,
    input  logic       obi_err_i,
    output logic       obi_rready_o,
    input  fifo_cnt_t  space_i,
    output logic       data_valid_o,
    output data_beat_t data_o,
    output logic       busy_o
);

    logic       room_ok;
    logic       bypass;
    logic       gnt_fire;
    logic       meta_ready;
    logic       meta_valid;
    read_beat_t meta_beat;
    out_cnt_t   outstanding;
    id_t        id_q;

    // Metadata of granted reads, popped as their data returns in order
    dma_stream_fifo #(
        .payload_t ( read_beat_t          ),
        .DEPTH     ( `DMA_MAX_OUTSTANDING )
    ) meta_fifo_inst (
        .clk_i       ( clk_i        ),
        .reset_i     ( reset_i      ),
        .in_valid_i  ( gnt_fire     ),
        .in_ready_o  ( meta_ready   ),
        .in_data_i   ( beat_i       ),
        .out_valid_o ( meta_valid   ),
        .out_ready_i ( obi_rvalid_i ),
        .out_data_o  ( meta_beat    ),
        .count_o     ( outstanding  )
    );

    // Downstream must hold every pending return plus the new one
    assign room_ok  = space_i > outstanding;
    assign obi_req_o = beat_valid_i && !beat_i.reject && meta_ready && room_ok;
    assign gnt_fire = obi_req_o && obi_gnt_i;

    // Rejected beats pass only once older reads have drained
    assign bypass = beat_valid_i && beat_i.reject && !meta_valid && (space_i != '0);

    assign beat_ready_o = gnt_fire || bypass;
    assign obi_addr_o   = beat_i.src_addr;
    assign obi_we_o     = 1'b0;
    assign obi_be_o     = '1;
    assign obi_id_o     = id_q;
    assign obi_rready_o = 1'b1;
    assign data_valid_o = obi_rvalid_i || bypass;
    assign busy_o       = meta_valid;

    always_comb begin
        if (obi_rvalid_i) begin
            data_o.dst_addr = meta_beat.dst_addr;
            data_o.first    = meta_beat.first;
            data_o.last     = meta_beat.last;
            data_o.tf_last  = meta_beat.tf_last;
            data_o.reject   = meta_beat.reject;
            data_o.data     = obi_rdata_i;
            data_o.rd_err   = obi_err_i;
            data_o.src_addr = meta_beat.src_addr;
        end else begin
            data_o.dst_addr = beat_i.dst_addr;
            data_o.first    = beat_i.first;
            data_o.last     = beat_i.last;
            data_o.tf_last  = beat_i.tf_last;
            data_o.reject   = beat_i.reject;
            data_o.data     = '0;
            data_o.rd_err   = 1'b0;
            data_o.src_addr = beat_i.src_addr;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            id_q <= '0;
        end else if (gnt_fire) begin
            id_q <= id_q + 1'b1;
        end
    end

    assert property (@(posedge clk_i) disable iff (reset_i)
        obi_rvalid_i |-> meta_valid);

    // The space reservation never withdraws a request waiting for its grant
    assert property (@(posedge clk_i) disable iff (reset_i)
        obi_req_o && !obi_gnt_i |=> obi_req_o && $stable(obi_addr_o));

endmodule

/* design/dma_init_writer.sv */
module dma_init_writer import dma_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       data_valid_i,
    output logic       data_ready_o,
    input  data_beat_t data_i,
    output logic       init_req_valid_o,
    input  logic       init_req_ready_i,
    output addr_t      init_cfg_o,
    output data_t      init_term_o,
    output strb_t      init_strb_o,
    output id_t        init_id_o,
    input  logic       init_rsp_valid_i,
    output logic       init_rsp_ready_o,
    output logic       rsp_valid_o,
    input  logic       rsp_ready_i,
    output logic       rsp_error_o,
    output err_kind_e  rsp_kind_o,
    output addr_t      rsp_addr_o,
    output logic       rsp_last_o,
    output logic       busy_o
);

    logic      need_write;
    logic      beat_err;
    logic      hold;
    logic      beat_fire;
    logic      wr_fire;
    logic      ack_fire;
    logic      in_tf_q;
    logic      drain_q;
    logic      rsp_valid_q;
    len_t      pend_q;
    id_t       id_q;
    logic      err_q;
    err_kind_e kind_q;
    addr_t     addr_q;
    logic      last_q;

    assign need_write = !data_i.reject && !data_i.rd_err;
    assign beat_err   = data_i.reject || data_i.rd_err;
    // Next transfer waits until this one's response is taken
    assign hold       = drain_q || rsp_valid_q;

    assign init_req_valid_o = data_valid_i && need_write && !hold;
    assign data_ready_o     = !hold && (!need_write || init_req_ready_i);
    assign beat_fire        = data_valid_i && data_ready_o;
    assign wr_fire          = init_req_valid_o && init_req_ready_i;
    assign ack_fire         = init_rsp_valid_i && init_rsp_ready_o;

    assign init_cfg_o       = data_i.dst_addr;
    assign init_term_o      = data_i.data;
    assign init_strb_o      = '1;
    assign init_id_o        = id_q;
    assign init_rsp_ready_o = 1'b1;

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_error_o = err_q;
    assign rsp_kind_o  = kind_q;
    assign rsp_addr_o  = addr_q;
    assign rsp_last_o  = last_q;
    assign busy_o      = in_tf_q || hold || (pend_q != '0);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            in_tf_q     <= 1'b0;
            drain_q     <= 1'b0;
            rsp_valid_q <= 1'b0;
            pend_q      <= '0;
            id_q        <= '0;
        end else begin
            if (wr_fire) begin
                id_q <= id_q + 1'b1;
            end
            case ({wr_fire, ack_fire})
                2'b10:   pend_q <= pend_q + 1'b1;
                2'b01:   pend_q <= pend_q - 1'b1;
                default: pend_q <= pend_q;
            endcase
            if (beat_fire) begin
                in_tf_q <= !data_i.last;
            end
            // Response rises once every write of the transfer is acknowledged
            if (beat_fire && data_i.last) begin
                drain_q <= 1'b1;
            end else if (drain_q && pend_q == '0) begin
                drain_q     <= 1'b0;
                rsp_valid_q <= 1'b1;
            end
            if (rsp_valid_q && rsp_ready_i) begin
                rsp_valid_q <= 1'b0;
            end
        end
    end

    // First beat opens a new record, later beats keep only the first error
    always_ff @(posedge clk_i) begin
        if (beat_fire) begin
            if (data_i.first || (!err_q && beat_err)) begin
                err_q  <= beat_err;
                kind_q <= data_i.reject ? ERR_DECODE : (data_i.rd_err ? ERR_READ : ERR_NONE);
                addr_q <= beat_err ? data_i.src_addr : '0;
            end
            if (data_i.last) begin
                last_q <= data_i.tf_last;
            end
        end
    end

    assert property (@(posedge clk_i) disable iff (reset_i)
        init_rsp_valid_i |-> pend_q != '0);

endmodule

/* design/dma_backend_top.sv */
`include "dma_defines.svh"

module dma_backend_top import dma_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      req_valid_i,
    output logic      req_ready_o,
    input  len_t      req_length_i,
    input  addr_t     req_src_addr_i,
    input  addr_t     req_dst_addr_i,
    input  logic      req_last_i,
    output logic      rsp_valid_o,
    input  logic      rsp_ready_i,
    output logic      rsp_error_o,
    output err_kind_e rsp_kind_o,
    output addr_t     rsp_addr_o,
    output logic      rsp_last_o,
    output logic      obi_req_o,
    output addr_t     obi_addr_o,
    output logic      obi_we_o,
    output strb_t     obi_be_o,
    output id_t       obi_id_o,
    input  logic      obi_gnt_i,
    input  logic      obi_rvalid_i,
    input  data_t     obi_rdata_i,
    input  logic      obi_err_i,
    output logic      obi_rready_o,
    output logic      init_req_valid_o,
    input  logic      init_req_ready_i,
    output addr_t     init_cfg_o,
    output data_t     init_term_o,
    output strb_t     init_strb_o,
    output id_t       init_id_o,
    input  logic      init_rsp_valid_i,
    output logic      init_rsp_ready_o,
    output logic      busy_o
);

    read_beat_t dec_beat;
    logic       dec_beat_valid;
    logic       dec_beat_ready;
    read_beat_t rd_beat;
    logic       rd_beat_valid;
    logic       rd_beat_ready;
    data_beat_t rdr_data;
    logic       rdr_data_valid;
    logic       data_fifo_ready;
    fifo_cnt_t  data_fifo_count;
    fifo_cnt_t  data_space;
    data_beat_t wr_data;
    logic       wr_data_valid;
    logic       wr_data_ready;
    logic       dec_busy;
    logic       rdr_busy;
    logic       wr_busy;

    dma_burst_decoder decoder_inst (
        .*,
        .beat_valid_o ( dec_beat_valid ),
        .beat_ready_i ( dec_beat_ready ),
        .beat_o       ( dec_beat       ),
        .busy_o       ( dec_busy       )
    );

    dma_stream_fifo #(
        .payload_t ( read_beat_t     ),
        .DEPTH     ( `DMA_FIFO_DEPTH )
    ) read_fifo_inst (
        .clk_i       ( clk_i          ),
        .reset_i     ( reset_i        ),
        .in_valid_i  ( dec_beat_valid ),
        .in_ready_o  ( dec_beat_ready ),
        .in_data_i   ( dec_beat       ),
        .out_valid_o ( rd_beat_valid  ),
        .out_ready_i ( rd_beat_ready  ),
        .out_data_o  ( rd_beat        ),
        .count_o     (                )
    );

    // Free entries of the data FIFO, reserved by the reader for returns
    assign data_space = fifo_cnt_t'(`DMA_FIFO_DEPTH) - data_fifo_count;

    dma_obi_reader reader_inst (
        .*,
        .beat_valid_i ( rd_beat_valid  ),
        .beat_ready_o ( rd_beat_ready  ),
        .beat_i       ( rd_beat        ),
        .space_i      ( data_space     ),
        .data_valid_o ( rdr_data_valid ),
        .data_o       ( rdr_data       ),
        .busy_o       ( rdr_busy       )
    );

    dma_stream_fifo #(
        .payload_t ( data_beat_t     ),
        .DEPTH     ( `DMA_FIFO_DEPTH )
    ) data_fifo_inst (
        .clk_i       ( clk_i           ),
        .reset_i     ( reset_i         ),
        .in_valid_i  ( rdr_data_valid  ),
        .in_ready_o  ( data_fifo_ready ),
        .in_data_i   ( rdr_data        ),
        .out_valid_o ( wr_data_valid   ),
        .out_ready_i ( wr_data_ready   ),
        .out_data_o  ( wr_data         ),
        .count_o     ( data_fifo_count )
    );

    dma_init_writer writer_inst (
        .*,
        .data_valid_i ( wr_data_valid ),
        .data_ready_o ( wr_data_ready ),
        .data_i       ( wr_data       ),
        .busy_o       ( wr_busy       )
    );

    assign busy_o = dec_busy || rdr_busy || wr_busy || rd_beat_valid || wr_data_valid;

    // Reader has no back-pressure, its reservation must keep the data FIFO open
    assert property (@(posedge clk_i) disable iff (reset_i)
        rdr_data_valid |-> data_fifo_ready);

endmodule

/* test/tb_dma_tasks.svh */
// Model word for a source address
function automatic data_t model_word(input addr_t a);
    return a ^ 32'hA5A5_0000;
endfunction

function automatic logic in_err_window(input addr_t a);
    return (a >= ERR_LO) && (a < ERR_HI);
endfunction

// True with a probability of pct percent
function automatic logic chance(input int pct);
    return ({$random(seed)} % 100) < pct;
endfunction

// One clock edge of the OBI source, the write sink and the response collector
task automatic step_models();
    addr_t    a;
    rsp_rec_t r;
    if (reset_i) begin
        obi_gnt_i        <= 1'b0;
        obi_rvalid_i     <= 1'b0;
        obi_err_i        <= 1'b0;
        init_req_ready_i <= 1'b0;
        init_rsp_valid_i <= 1'b0;
        rsp_ready_i      <= 1'b0;
        rd_pending.delete();
        acks_owed = 0;
    end else begin
        if (obi_req_o && obi_gnt_i) begin
            rd_pending.push_back(obi_addr_o);
            obi_reads++;
            // Reads are whole words
            check_bit(cur_test, "obi_we_o", 1'b0, obi_we_o);
            check_bit(cur_test, "obi_be_o all ones", 1'b1, &obi_be_o);
            check_bit(cur_test, "obi_id_o unknown", 1'b0, $isunknown(obi_id_o));
        end
        if (obi_rvalid_i) begin
            check_bit(cur_test, "obi_rready_o", 1'b1, obi_rready_o);
        end
        // Data comes back in grant order
        if (rd_pending.size() != 0 && !chance(stall_pct)) begin
            a = rd_pending.pop_front();
            obi_rvalid_i <= 1'b1;
            obi_rdata_i  <= model_word(a);
            obi_err_i    <= in_err_window(a);
        end else begin
            obi_rvalid_i <= 1'b0;
            obi_err_i    <= 1'b0;
        end
        obi_gnt_i <= !chance(stall_pct);
        if (init_req_valid_o && init_req_ready_i) begin
            wmem[init_cfg_o] = init_term_o;
            writes++;
            acks_owed++;
            check_bit(cur_test, "init_strb_o all ones", 1'b1, &init_strb_o);
            check_bit(cur_test, "init_id_o unknown", 1'b0, $isunknown(init_id_o));
        end
        if (init_rsp_valid_i) begin
            check_bit(cur_test, "init_rsp_ready_o", 1'b1, init_rsp_ready_o);
        end
        if (acks_owed != 0 && !chance(stall_pct)) begin
            init_rsp_valid_i <= 1'b1;
            acks_owed--;
        end else begin
            init_rsp_valid_i <= 1'b0;
        end
        init_req_ready_i <= 1'b1;
        if (rsp_valid_o && rsp_ready_i) begin
            r.err  = rsp_error_o;
            r.kind = rsp_kind_o;
            r.addr = rsp_addr_o;
            r.last = rsp_last_o;
            rsp_q.push_back(r);
        end
        rsp_ready_i <= !chance(stall_pct);
    end
endtask

task automatic check_word(input string name, input addr_t addr, input data_t exp,
                          input data_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("Fail %s: word at %h expected %h, actual %h", name, addr, exp, act);
    end
endtask

task automatic check_bit(input string name, input string what, input logic exp,
                         input logic act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("Fail %s: %s expected %b, actual %b", name, what, exp, act);
    end
endtask

task automatic check_count(input string name, input string what, input int exp,
                           input int act);
    checks++;
    if (act != exp) begin
        errors++;
        $display("Fail %s: %s expected %0d, actual %0d", name, what, exp, act);
    end
endtask

task automatic check_rsp(input string name, input int idx, input logic exp_err,
                         input err_kind_e exp_kind, input addr_t exp_addr,
                         input logic exp_last);
    rsp_rec_t r;
    checks++;
    if (idx >= rsp_q.size()) begin
        errors++;
        $display("Error in %s: response %0d never arrived", name, idx);
    end else begin
        r = rsp_q[idx];
        if (r.err !== exp_err || r.kind !== exp_kind || r.addr !== exp_addr
                || r.last !== exp_last) begin
            errors++;
            $write("Fail %s: response %0d expected err %b kind %0d addr %h last %b, ",
                   name, idx, exp_err, exp_kind, exp_addr, exp_last);
            $display("actual err %b kind %0d addr %h last %b",
                     r.err, r.kind, r.addr, r.last);
        end
    end
endtask

// Words whose read fails must stay unwritten
task automatic check_copy(input string name, input addr_t src, input addr_t dst,
                          input int words);
    addr_t s;
    addr_t d;
    for (int i = 0; i < words; i++) begin
        s = src + addr_t'(4 * i);
        d = dst + addr_t'(4 * i);
        if (in_err_window(s)) begin
            checks++;
            if (wmem.exists(d)) begin
                errors++;
                $display("Error in %s: word at %h written although its read failed", name, d);
            end
        end else if (!wmem.exists(d)) begin
            checks++;
            errors++;
            $display("Error in %s: word at %h was never written", name, d);
        end else begin
            check_word(name, d, model_word(s), wmem[d]);
        end
    end
endtask

task automatic send_req(input string name, input len_t len, input addr_t src,
                        input addr_t dst, input logic last);
    int   cycles;
    logic taken;
    cycles = 0;
    taken  = 1'b0;
    @(posedge clk_i);
    req_valid_i    <= 1'b1;
    req_length_i   <= len;
    req_src_addr_i <= src;
    req_dst_addr_i <= dst;
    req_last_i     <= last;
    while (!taken && cycles < TIMEOUT) begin
        @(posedge clk_i);
        taken = req_ready_o;
        cycles++;
    end
    req_valid_i <= 1'b0;
    if (!taken) begin
        errors++;
        $display("Timeout in %s: request not accepted within %0d cycles", name, TIMEOUT);
    end
endtask

task automatic wait_rsp(input string name, input int n);
    int cycles;
    cycles = 0;
    while (rsp_q.size() < n && cycles < TIMEOUT) begin
        @(negedge clk_i);
        cycles++;
    end
    if (rsp_q.size() < n) begin
        errors++;
        $display("Timeout in %s: got %0d of %0d responses", name, rsp_q.size(), n);
    end
endtask

task automatic clear_models();
    wmem.delete();
    rsp_q.delete();
    obi_reads = 0;
    writes    = 0;
endtask

task automatic end_test(input string name, input int err_start);
    tests++;
    $display("Test %-14s %s", name, (errors == err_start) ? "passed" : "failed");
endtask

/* test/tb_dma_backend.sv */
module tb_dma_backend import dma_pkg::*; ();

    localparam int    TIMEOUT = 2000;
    localparam addr_t ERR_LO  = 32'h0000_500C;
    localparam addr_t ERR_HI  = 32'h0000_5014;

    typedef struct packed {
        logic      err;
        err_kind_e kind;
        addr_t     addr;
        logic      last;
    } rsp_rec_t;

    logic      clk_i;
    logic      reset_i;
    logic      req_valid_i;
    logic      req_ready_o;
    len_t      req_length_i;
    addr_t     req_src_addr_i;
    addr_t     req_dst_addr_i;
    logic      req_last_i;
    logic      rsp_valid_o;
    logic      rsp_ready_i;
    logic      rsp_error_o;
    err_kind_e rsp_kind_o;
    addr_t     rsp_addr_o;
    logic      rsp_last_o;
    logic      obi_req_o;
    addr_t     obi_addr_o;
    logic      obi_we_o;
    strb_t     obi_be_o;
    id_t       obi_id_o;
    logic      obi_gnt_i;
    logic      obi_rvalid_i;
    data_t     obi_rdata_i;
    logic      obi_err_i;
    logic      obi_rready_o;
    logic      init_req_valid_o;
    logic      init_req_ready_i;
    addr_t     init_cfg_o;
    data_t     init_term_o;
    strb_t     init_strb_o;
    id_t       init_id_o;
    logic      init_rsp_valid_i;
    logic      init_rsp_ready_o;
    logic      busy_o;

    integer    seed      = 36191;
    int        stall_pct = 25;
    int        errors    = 0;
    int        checks    = 0;
    int        tests     = 0;
    int        obi_reads = 0;
    int        writes    = 0;
    int        acks_owed = 0;
    string     cur_test  = "reset_idle";
    addr_t     rd_pending [$];
    data_t     wmem [addr_t];
    rsp_rec_t  rsp_q [$];

    dma_backend_top dma_backend_top_inst (.*);

    `include "tb_dma_tasks.svh"

    task automatic test_reset_idle();
        int err_start;
        err_start = errors;
        cur_test  = "reset_idle";
        @(posedge clk_i);
        check_bit("reset_idle", "rsp_valid_o", 1'b0, rsp_valid_o);
        check_bit("reset_idle", "obi_req_o", 1'b0, obi_req_o);
        check_bit("reset_idle", "init_req_valid_o", 1'b0, init_req_valid_o);
        check_bit("reset_idle", "busy_o", 1'b0, busy_o);
        repeat (8) @(posedge clk_i);
        check_bit("reset_idle", "busy_o after idle", 1'b0, busy_o);
        end_test("reset_idle", err_start);
    endtask

    task automatic test_single_copy();
        int err_start;
        err_start = errors;
        cur_test  = "single_copy";
        clear_models();
        send_req("single_copy", 16'd64, 32'h0000_1000, 32'h0000_8000, 1'b1);
        @(negedge clk_i);
        check_bit("single_copy", "busy_o during copy", 1'b1, busy_o);
        wait_rsp("single_copy", 1);
        check_bit("single_copy", "busy_o after response", 1'b0, busy_o);
        check_copy("single_copy", 32'h0000_1000, 32'h0000_8000, 16);
        check_count("single_copy", "writes", 16, writes);
        check_rsp("single_copy", 0, 1'b0, ERR_NONE, '0, 1'b1);
        end_test("single_copy", err_start);
    endtask

    task automatic test_back_to_back();
        int err_start;
        err_start = errors;
        cur_test  = "back_to_back";
        clear_models();
        send_req("back_to_back", 16'd16, 32'h0000_2000, 32'h0000_8400, 1'b0);
        send_req("back_to_back", 16'd28, 32'h0000_2100, 32'h0000_8500, 1'b0);
        send_req("back_to_back", 16'd8, 32'h0000_2200, 32'h0000_8600, 1'b1);
        wait_rsp("back_to_back", 3);
        check_copy("back_to_back", 32'h0000_2000, 32'h0000_8400, 4);
        check_copy("back_to_back", 32'h0000_2100, 32'h0000_8500, 7);
        check_copy("back_to_back", 32'h0000_2200, 32'h0000_8600, 2);
        // Only the request marked last sets rsp_last_o
        check_rsp("back_to_back", 0, 1'b0, ERR_NONE, '0, 1'b0);
        check_rsp("back_to_back", 1, 1'b0, ERR_NONE, '0, 1'b0);
        check_rsp("back_to_back", 2, 1'b0, ERR_NONE, '0, 1'b1);
        end_test("back_to_back", err_start);
    endtask

    task automatic test_zero_length();
        int err_start;
        err_start = errors;
        cur_test  = "zero_length";
        clear_models();
        send_req("zero_length", 16'd0, 32'h0000_3000, 32'h0000_9000, 1'b1);
        wait_rsp("zero_length", 1);
        check_count("zero_length", "OBI reads", 0, obi_reads);
        check_count("zero_length", "writes", 0, writes);
        check_rsp("zero_length", 0, 1'b1, ERR_DECODE, 32'h0000_3000, 1'b1);
        end_test("zero_length", err_start);
    endtask

    task automatic test_read_error();
        int err_start;
        err_start = errors;
        cur_test  = "read_error";
        clear_models();
        // Two words fail, the response names the first
        send_req("read_error", 16'd32, 32'h0000_5000, 32'h0000_A000, 1'b1);
        wait_rsp("read_error", 1);
        check_copy("read_error", 32'h0000_5000, 32'h0000_A000, 8);
        check_count("read_error", "writes", 6, writes);
        check_rsp("read_error", 0, 1'b1, ERR_READ, ERR_LO, 1'b1);
        end_test("read_error", err_start);
    endtask

    task automatic test_stall_copy();
        int err_start;
        err_start = errors;
        cur_test  = "stall_copy";
        clear_models();
        stall_pct = 60;
        send_req("stall_copy", 16'd128, 32'h0000_6000, 32'h0000_C000, 1'b1);
        wait_rsp("stall_copy", 1);
        // Give a stray second response time to show up
        repeat (40) @(negedge clk_i);
        stall_pct = 25;
        check_copy("stall_copy", 32'h0000_6000, 32'h0000_C000, 32);
        check_count("stall_copy", "responses", 1, rsp_q.size());
        check_rsp("stall_copy", 0, 1'b0, ERR_NONE, '0, 1'b1);
        end_test("stall_copy", err_start);
    endtask

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    initial begin
        forever begin
            @(posedge clk_i);
            step_models();
        end
    end

    initial begin
        reset_i          <= 1'b1;
        req_valid_i      <= 1'b0;
        req_length_i     <= '0;
        req_src_addr_i   <= '0;
        req_dst_addr_i   <= '0;
        req_last_i       <= 1'b0;
        rsp_ready_i      <= 1'b0;
        obi_gnt_i        <= 1'b0;
        obi_rvalid_i     <= 1'b0;
        obi_rdata_i      <= '0;
        obi_err_i        <= 1'b0;
        init_req_ready_i <= 1'b0;
        init_rsp_valid_i <= 1'b0;
        repeat (10) @(posedge clk_i);
        reset_i <= 1'b0;
        test_reset_idle();
        test_single_copy();
        test_back_to_back();
        test_zero_length();
        test_read_error();
        test_stall_copy();
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+design
+incdir+test
design/dma_pkg.sv
design/dma_stream_fifo.sv
design/dma_burst_decoder.sv
design/dma_obi_reader.sv
design/dma_init_writer.sv
design/dma_backend_top.sv
test/tb_dma_backend.sv
